//--- Makefile
SIM      = verilator
TOP      = anchor_updater_tb
FILELIST = vlog.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = run.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/anchor_updater.sv
`timescale 1ns/10ps

module anchor_updater (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  octree_pkg::update_op_e req_op_i,
  input  octree_pkg::pos_code_t  req_pos_i,
  output logic                   rsp_valid_o,
  output logic                   sram_cen_o,
  output logic                   sram_gwen_o,
  output octree_pkg::sram_addr_t sram_addr_o,
  output octree_pkg::sram_data_t sram_d_o,
  input  octree_pkg::sram_data_t sram_q_i
);
  import octree_pkg::*;

  logic              walk_load;
  logic              walk_ascend;
  update_op_e        op;
  logic              target_self;
  logic              at_root;
  logic              propagate;
  level_t            level;
  logic [PATH_W-1:0] path;
  lane_sel_t         lane;
  offset_t           slot;

  update_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .rsp_valid_o   (rsp_valid_o),
    .walk_load_o   (walk_load),
    .walk_ascend_o (walk_ascend),
    .op_o          (op),
    .target_self_o (target_self),
    .at_root_i     (at_root),
    .propagate_i   (propagate),
    .sram_cen_o    (sram_cen_o),
    .sram_gwen_o   (sram_gwen_o)
  );

  level_walker u_walker (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_i    (walk_load),
    .ascend_i  (walk_ascend),
    .pos_i     (req_pos_i),
    .level_o   (level),
    .path_o    (path),
    .at_root_o (at_root)
  );

  node_addr_gen u_addr (
    .level_i     (level),
    .path_i      (path),
    .sram_addr_o (sram_addr_o),
    .lane_o      (lane),
    .slot_o      (slot)
  );

  lane_update u_lane (
    .rdata_i       (sram_q_i),
    .lane_i        (lane),
    .slot_i        (slot),
    .op_i          (op),
    .target_self_i (target_self),
    .wdata_o       (sram_d_o),
    .propagate_o   (propagate)
  );

endmodule

//--- rtl/lane_update.sv
`timescale 1ns/10ps

module lane_update (
  input  octree_pkg::sram_data_t rdata_i,
  input  octree_pkg::lane_sel_t  lane_i,
  input  octree_pkg::offset_t    slot_i,
  input  octree_pkg::update_op_e op_i,
  input  logic                   target_self_i,
  output octree_pkg::sram_data_t wdata_o,
  output logic                   propagate_o
);
  import octree_pkg::*;

  lane_t             lane_old;
  lane_t             lane_new;
  lane_t             bit_mask;
  logic [OFFSET_W:0] bit_idx;

  always_comb begin
    lane_old = rdata_i[lane_i*LANE_W +: LANE_W];

    // child bit at 2*slot, self bit just above it
    bit_idx  = {slot_i, target_self_i};
    bit_mask = lane_t'(1) << bit_idx;

    if (op_i == OP_ADD) begin
      lane_new = lane_old | bit_mask;
    end else begin
      lane_new = lane_old & ~bit_mask;
    end

    // other lanes pass through untouched
    wdata_o = rdata_i;
    wdata_o[lane_i*LANE_W +: LANE_W] = lane_new;

    // add climbs when the group was empty, delete when it became empty
    if (op_i == OP_ADD) begin
      propagate_o = (lane_old == '0);
    end else begin
      propagate_o = (lane_new == '0);
    end
  end

endmodule

//--- rtl/level_walker.sv
`timescale 1ns/10ps

module level_walker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_i,
  input  logic                          ascend_i,
  input  octree_pkg::pos_code_t         pos_i,
  output octree_pkg::level_t            level_o,
  output logic [octree_pkg::PATH_W-1:0] path_o,
  output logic                          at_root_o
);
  import octree_pkg::*;

  level_t            level_q;
  logic [PATH_W-1:0] path_q;

  // level counts down toward the root, one per ancestor step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= '0;
    end else if (load_i) begin
      level_q <= pos_i[POS_W-1 -: LEVEL_W];
    end else if (ascend_i) begin
      level_q <= level_q - 1'b1;
    end
  end

  // path stays fixed for the whole walk
  always_ff @(posedge clk) begin
    if (load_i) begin
      path_q <= pos_i[PATH_W-1:0];
    end
  end

  assign level_o   = level_q;
  assign path_o    = path_q;
  assign at_root_o = (level_q == '0);

  a_load_level_range : assert property (@(posedge clk) disable iff (!rst_n)
    load_i |=> (level_o < NUM_LEVELS));

  a_no_ascend_at_root : assert property (@(posedge clk) disable iff (!rst_n)
    ascend_i |-> !at_root_o);

endmodule

//--- rtl/node_addr_gen.sv
`timescale 1ns/10ps

module node_addr_gen (
  input  octree_pkg::level_t            level_i,
  input  logic [octree_pkg::PATH_W-1:0] path_i,
  output octree_pkg::sram_addr_t        sram_addr_o,
  output octree_pkg::lane_sel_t         lane_o,
  output octree_pkg::offset_t           slot_o
);
  import octree_pkg::*;

  offset_t            offsets [NUM_LEVELS];
  logic [GROUP_W-1:0] base;
  logic [GROUP_W-1:0] prefix;
  logic [GROUP_W-1:0] group;

  always_comb begin
    // offset 0 sits in the top slice of the path
    for (int i = 0; i < NUM_LEVELS; i++) begin
      offsets[i] = path_i[PATH_W-1-i*OFFSET_W -: OFFSET_W];
    end

    // octal number of the offsets above the current level
    prefix = '0;
    for (int i = 0; i < NUM_LEVELS - 1; i++) begin
      if (i < level_i) begin
        prefix = {prefix[GROUP_W-OFFSET_W-1:0], offsets[i]};
      end
    end

    base   = '0;
    slot_o = '0;
    for (int l = 0; l < NUM_LEVELS; l++) begin
      if (level_i == l) begin
        base   = GROUP_W'(LEVEL_BASE[l]);
        slot_o = offsets[l];
      end
    end

    group = base + prefix;
  end

  // four groups per word, lane 0 in the low bits
  assign sram_addr_o = group[GROUP_W-1 -: ADDR_W];
  assign lane_o      = group[LANE_SEL_W-1:0];

endmodule

//--- rtl/octree_pkg.sv
package octree_pkg;

  // tree geometry
  localparam int LEVEL_W    = 3;
  localparam int NUM_LEVELS = 5;
  localparam int OFFSET_W   = 3;

  // position code: level on top, offset 0 in the highest slice below it
  localparam int POS_W  = LEVEL_W + NUM_LEVELS * OFFSET_W;
  localparam int PATH_W = POS_W - LEVEL_W;

  // sram word layout
  localparam int DATA_W         = 64;
  localparam int LANE_W         = 16;
  localparam int LANES_PER_WORD = DATA_W / LANE_W;
  localparam int LANE_SEL_W     = $clog2(LANES_PER_WORD);
  localparam int ADDR_W         = 11;

  // group number covers word address and lane
  localparam int GROUP_W = ADDR_W + LANE_SEL_W;

  // first group number of each level
  localparam int LEVEL_BASE [NUM_LEVELS] = '{0, 1, 9, 73, 585};

  typedef logic [LEVEL_W-1:0]    level_t;
  typedef logic [OFFSET_W-1:0]   offset_t;
  typedef logic [POS_W-1:0]      pos_code_t;
  typedef logic [ADDR_W-1:0]     sram_addr_t;
  typedef logic [DATA_W-1:0]     sram_data_t;
  typedef logic [LANE_W-1:0]     lane_t;
  typedef logic [LANE_SEL_W-1:0] lane_sel_t;

  typedef enum logic {
    OP_ADD    = 1'b0,
    OP_DELETE = 1'b1
  } update_op_e;

  // one tree step is a READ followed by a WRITE
  typedef enum logic [1:0] {
    IDLE,
    READ,
    WRITE,
    DONE
  } fsm_state_e;

endpackage

//--- rtl/update_fsm.sv
`timescale 1ns/10ps

module update_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  octree_pkg::update_op_e req_op_i,
  output logic                   rsp_valid_o,
  output logic                   walk_load_o,
  output logic                   walk_ascend_o,
  output octree_pkg::update_op_e op_o,
  output logic                   target_self_o,
  input  logic                   at_root_i,
  input  logic                   propagate_i,
  output logic                   sram_cen_o,
  output logic                   sram_gwen_o
);
  import octree_pkg::*;

  fsm_state_e state;
  update_op_e op_q;
  logic       first_step_q;
  logic       accept;

  assign accept = req_valid_i && req_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      op_q         <= OP_ADD;
      first_step_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state        <= READ;
            op_q         <= req_op_i;
            first_step_q <= 1'b1;
          end
        end
        READ: begin
          state <= WRITE;
        end
        WRITE: begin
          // climb only while the group changed emptiness and a parent exists
          if (walk_ascend_o) begin
            state        <= READ;
            first_step_q <= 1'b0;
          end else begin
            state <= DONE;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign req_ready_o   = (state == IDLE);
  assign rsp_valid_o   = (state == DONE);
  assign walk_load_o   = accept;
  assign walk_ascend_o = (state == WRITE) && propagate_i && !at_root_i;
  assign op_o          = op_q;
  // self bit on the requested node, child bit on every ancestor
  assign target_self_o = first_step_q;

  // read in READ, write back in WRITE, both active low
  assign sram_cen_o  = !((state == READ) || (state == WRITE));
  assign sram_gwen_o = !(state == WRITE);

  // busy from acceptance until the done pulse has passed
  a_no_accept_busy : assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !req_ready_o);

  a_rsp_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_o |=> !rsp_valid_o);

  // every write is the second half of a read-modify-write step
  a_write_after_read : assert property (@(posedge clk) disable iff (!rst_n)
    !sram_gwen_o |-> !sram_cen_o && $past(!sram_cen_o && sram_gwen_o));

endmodule

//--- include/tb_tree_model.svh
`ifndef TB_TREE_MODEL_SVH
`define TB_TREE_MODEL_SVH

// shadow copy of the occupancy bits, one entry per sram word
sram_data_t model_mem [2048];
int         level_first [5] = '{0, 1, 9, 73, 585};
int         errors = 0;

// offsets above the level read as one octal number
function automatic int group_of(input int lvl, input pos_code_t pos);
  int g;
  g = 0;
  for (int i = 0; i < lvl; i++) begin
    g = g * 8 + int'(pos[14-3*i -: 3]);
  end
  return level_first[lvl] + g;
endfunction

// self bit first, then child bits while the group changes emptiness
task automatic model_apply(input update_op_e op, input pos_code_t pos);
  int    lvl;
  int    grp;
  int    bit_pos;
  int    self_bit;
  logic  climb;
  lane_t lane_before;
  lane_t lane_after;
  lvl      = int'(pos[17:15]);
  self_bit = 1;
  climb    = 1'b1;
  while (climb && lvl >= 0) begin
    grp         = group_of(lvl, pos);
    lane_before = model_mem[grp/4][(grp%4)*16 +: 16];
    bit_pos     = 2 * int'(pos[14-3*lvl -: 3]) + self_bit;
    lane_after  = lane_before;
    lane_after[bit_pos] = (op == OP_ADD);
    model_mem[grp/4][(grp%4)*16 +: 16] = lane_after;
    climb    = (op == OP_ADD) ? (lane_before == '0) : (lane_after == '0);
    self_bit = 0;
    lvl--;
  end
endtask

task automatic check_word(input string name, input sram_data_t exp, input sram_data_t act);
  if (act !== exp) begin
    $display("** Error %s: expected %h, actual %h", name, exp, act);
    errors++;
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("** Error %s: expected %b, actual %b", name, exp, act);
    errors++;
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    $display("** Error %s: expected %0d, actual %0d", name, exp, act);
    errors++;
  end
endtask

`endif

//--- verification/anchor_updater_tb.sv
`timescale 1ns/10ps

module anchor_updater_tb;
  import octree_pkg::*;

  logic       clk;
  logic       rst_n;
  logic       req_valid_i;
  logic       req_ready_o;
  update_op_e req_op_i;
  pos_code_t  req_pos_i;
  logic       rsp_valid_o;
  logic       sram_cen_o;
  logic       sram_gwen_o;
  sram_addr_t sram_addr_o;
  sram_data_t sram_d_o;
  sram_data_t sram_q_i = '0;
  sram_data_t mem [2048];
  int         wr_count = 0;
  int         rsp_count = 0;
  int         seed = 64;

  `include "tb_tree_model.svh"

  anchor_updater dut (.*);

  always #20 clk = ~clk;

  // single-port sram, read data arrives one cycle after the read
  always @(posedge clk) begin
    if (!sram_cen_o && !sram_gwen_o) begin
      mem[sram_addr_o] = sram_d_o;
      wr_count++;
    end else if (!sram_cen_o) begin
      sram_q_i <= mem[sram_addr_o];
    end
    if (rsp_valid_o) begin
      rsp_count++;
    end
  end

  // holds valid until the request is taken
  task automatic issue(input update_op_e op, input pos_code_t pos);
    int t;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_pos_i   = pos;
    t = 0;
    while (!req_ready_o && t < 200) begin
      @(negedge clk);
      t++;
    end
    if (!req_ready_o) begin
      $display("timeout: the updater never accepted a request");
      errors++;
    end
    @(negedge clk);
    req_valid_i = 1'b0;
    model_apply(op, pos);
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (!rsp_valid_o && t < 200) begin
      @(negedge clk);
      t++;
    end
    if (!rsp_valid_o) begin
      $display("timeout: no done pulse after a request");
      errors++;
    end
    @(negedge clk);
  endtask

  task automatic check_memory(input string name);
    for (int i = 0; i < 2048; i++) begin
      check_word($sformatf("%s word %0d", name, i), model_mem[i], mem[i]);
    end
  endtask

  task automatic tree_step(input string name, input update_op_e op, input pos_code_t pos,
                           input int writes);
    int start;
    start = wr_count;
    issue(op, pos);
    wait_done();
    check_count({name, " writes"}, writes, wr_count - start);
    check_memory(name);
  endtask

  task automatic test_reset();
    check_flag("reset ready", 1'b1, req_ready_o);
    check_flag("reset rsp_valid", 1'b0, rsp_valid_o);
    check_flag("reset cen", 1'b1, sram_cen_o);
    check_flag("reset gwen", 1'b1, sram_gwen_o);
    repeat (10) @(negedge clk);
    check_count("idle writes", 0, wr_count);
  endtask

  // offsets 3 5 1 6 2, then a sibling in the same level 4 group
  task automatic test_add();
    tree_step("add path", OP_ADD, {3'd4, 15'o35162}, 5);
    tree_step("add sibling", OP_ADD, {3'd4, 15'o35165}, 1);
  endtask

  task automatic test_delete();
    tree_step("delete sibling", OP_DELETE, {3'd4, 15'o35165}, 1);
    tree_step("delete last", OP_DELETE, {3'd4, 15'o35162}, 5);
  endtask

  task automatic test_random();
    int          start;
    level_t      lvl;
    logic [14:0] path;
    update_op_e  op;
    start = rsp_count;
    for (int n = 0; n < 30; n++) begin
      lvl = level_t'($unsigned($random(seed)) % 5);
      // offsets 0 or 1 only, so groups are shared often
      path = 15'($random(seed)) & 15'o11111;
      op   = ($random(seed) & 1) ? OP_DELETE : OP_ADD;
      issue(op, {lvl, path});
    end
    wait_done();
    check_count("random done pulses", 30, rsp_count - start);
    check_memory("random");
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_ADD;
    req_pos_i   = '0;
    for (int i = 0; i < 2048; i++) begin
      mem[i]       = '0;
      model_mem[i] = '0;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_add();
    test_delete();
    test_random();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/octree_pkg.sv
rtl/update_fsm.sv
rtl/level_walker.sv
rtl/node_addr_gen.sv
rtl/lane_update.sv
rtl/anchor_updater.sv
verification/anchor_updater_tb.sv
